// File: files.f
+incdir+logic
+incdir+verif
logic/frontend_pkg.sv
logic/block_predictor.sv
logic/ftq.sv
logic/ifu.sv
logic/frontend_top.sv
verif/frontend_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the fetch front end testbench with Verilator, run it and scan the log
set -eo pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module frontend_tb \
    -Mdir "$BUILD_DIR" -o frontend_sim

"./$BUILD_DIR/frontend_sim" | tee "$LOG_FILE"

if grep -q "Errors found" "$LOG_FILE"; then
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi

echo "Simulation passed"

// File: verif/frontend_model.svh
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

// Expected line requests in delivery order
fetch_req_t expected_q[$];

// Fall-through start address of block n
function automatic logic [`ADDR_W-1:0] block_start_pc(input int n);
    return `ADDR_W'(`RESET_PC) + `ADDR_W'(4 * `FETCH_WIDTH * n);
endfunction

// Instructions that fit before the next line boundary
function automatic int slots_in_first_line(input logic [`ADDR_W-1:0] pc);
    int room;
    room = (`LINE_BYTES - int'(pc % `LINE_BYTES)) / 4;
    if (room > `FETCH_WIDTH) begin
        room = `FETCH_WIDTH;
    end
    return room;
endfunction

// Mask with the lowest count slots set
function automatic logic [`FETCH_WIDTH-1:0] low_slots(input int count);
    logic [`FETCH_WIDTH-1:0] mask;
    mask = '0;
    for (int i = 0; i < count; i++) begin
        mask[i] = 1'b1;
    end
    return mask;
endfunction

// One request per touched line, only the final one carries last
task automatic append_block_requests(input int n);
    fetch_req_t         req;
    logic [`ADDR_W-1:0] pc;
    int                 head;
    pc   = block_start_pc(n);
    head = slots_in_first_line(pc);
    req           = '0;
    req.valid     = 1'b1;
    req.line_addr = pc - (pc % `LINE_BYTES);
    req.slot_mask = low_slots(head);
    req.idx       = IDX_W'(n % `QUEUE_SIZE);
    req.last      = (head == `FETCH_WIDTH);
    expected_q.push_back(req);
    if (head < `FETCH_WIDTH) begin
        // Rest of the block sits in the following line
        req.line_addr = req.line_addr + `ADDR_W'(`LINE_BYTES);
        req.slot_mask = ~low_slots(head);
        req.last      = 1'b1;
        expected_q.push_back(req);
    end
endtask

task automatic build_expected_stream(input int blocks);
    expected_q.delete();
    for (int n = 0; n < blocks; n++) begin
        append_block_requests(n);
    end
endtask

`endif

// File: verif/frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "frontend_cfg.svh"

module frontend_tb import frontend_pkg::*; ();

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int STREAM_BLOCKS = 300;
    localparam int TAIL_BLOCKS   = 40;
    localparam int MODEL_BLOCKS  = 400;
    localparam int STALL_PCT     = 30;
    localparam int COMMIT_PCT    = 60;
    localparam int MAX_STALL_RUN = 4;
    localparam int SETTLE_CYCLES = 16;
    // Two stalled requests per block plus a few cycles of transfer
    localparam int BLOCK_BUDGET  = 2 * MAX_STALL_RUN + 4;
    localparam int FILL_LIMIT    = `QUEUE_SIZE * BLOCK_BUDGET;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + SETTLE_CYCLES
        + (STREAM_BLOCKS + TAIL_BLOCKS + `QUEUE_SIZE) * BLOCK_BUDGET;

    logic       clk;
    logic       rst_n;
    logic       stall;
    logic       commit;
    fetch_req_t fetch_req;

    integer     seed;
    int         stall_run;
    bit         commit_en;
    int         delivered;
    int         committed;
    fetch_req_t prev_req;
    logic       prev_stall;
    int         stall_holds;
    string      current_test;
    int         check_count;
    int         error_count;
    int         test_checks;
    int         test_errors;

    `include "frontend_model.svh"

    frontend_top i_frontend_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_i     (stall),
        .commit_i    (commit),
        .fetch_req_o (fetch_req)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int percent_roll();
        return $unsigned($random(seed)) % 100;
    endfunction

    task automatic check_equal(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        test_checks++;
        assert (expected === actual) else begin
            $display("FAILED %s %s: expected %0h, actual %0h",
                     current_test, what, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        check_count++;
        test_checks++;
        assert (cond) else begin
            $display("Check failed in %s: %s", current_test, what);
            error_count++;
            test_errors++;
        end
    endtask

    // Match one new request against the head of the expected stream
    task automatic compare_request(input fetch_req_t got);
        fetch_req_t exp;
        if (expected_q.size() == 0) begin
            check_true(1'b0, "request seen beyond the end of the expected stream");
        end else begin
            exp = expected_q.pop_front();
            // Slot 0 always lives in the first line of a block
            if (exp.slot_mask[0]) begin
                delivered++;
            end
            check_equal("line_addr", 64'(exp.line_addr), 64'(got.line_addr));
            check_equal("slot_mask", 64'(exp.slot_mask), 64'(got.slot_mask));
            check_equal("idx", 64'(exp.idx), 64'(got.idx));
            check_equal("last", 64'(exp.last), 64'(got.last));
        end
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_checks  = 0;
        test_errors  = 0;
    endtask

    task automatic finish_test();
        $display("Test %s: %0d checks, %0d errors", current_test, test_checks, test_errors);
    endtask

    // Step past the edge so counters and controls are settled
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Random stall with a bounded run, commit only for delivered blocks
    always @(posedge clk) begin
        int roll;
        if (!rst_n) begin
            stall  <= 1'b0;
            commit <= 1'b0;
        end else begin
            roll = percent_roll();
            if (roll < STALL_PCT && stall_run < MAX_STALL_RUN) begin
                stall     <= 1'b1;
                stall_run = stall_run + 1;
            end else begin
                stall     <= 1'b0;
                stall_run = 0;
            end
            roll = percent_roll();
            if (commit_en && delivered > committed && roll < COMMIT_PCT) begin
                commit    <= 1'b1;
                committed = committed + 1;
            end else begin
                commit <= 1'b0;
            end
        end
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (prev_stall) begin
                stall_holds = stall_holds + 1;
                check_equal("held request", 64'(prev_req), 64'(fetch_req));
            end else if (fetch_req.valid) begin
                compare_request(fetch_req);
            end
            check_true(delivered - committed <= `QUEUE_SIZE - 1,
                       "more blocks outstanding than the queue can hold");
            prev_req   = fetch_req;
            prev_stall = stall;
        end
    end

    initial begin
        int wait_cycles;
        int held_blocks;
        clk         = 1'b0;
        rst_n       = 1'b0;
        stall       = 1'b0;
        commit      = 1'b0;
        seed        = 78;
        stall_run   = 0;
        commit_en   = 1'b0;
        delivered   = 0;
        committed   = 0;
        prev_req    = '0;
        prev_stall  = 1'b0;
        stall_holds = 0;
        check_count = 0;
        error_count = 0;
        build_expected_stream(MODEL_BLOCKS);

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        next_cycle();

        start_test("random_stream");
        commit_en = 1'b1;
        while (delivered < STREAM_BLOCKS) begin
            next_cycle();
        end
        finish_test();

        // Back-pressure with the back end silent
        start_test("commit_withheld");
        commit_en   = 1'b0;
        wait_cycles = 0;
        while (delivered - committed < `QUEUE_SIZE - 1 && wait_cycles < FILL_LIMIT) begin
            next_cycle();
            wait_cycles++;
        end
        check_true(delivered - committed == `QUEUE_SIZE - 1,
                   "queue did not fill while commits were withheld");
        held_blocks = delivered;
        repeat (SETTLE_CYCLES) next_cycle();
        check_equal("blocks delivered while full", 64'(held_blocks), 64'(delivered));
        finish_test();

        start_test("resume_after_commit");
        commit_en = 1'b1;
        while (delivered < STREAM_BLOCKS + TAIL_BLOCKS) begin
            next_cycle();
        end
        check_true(stall_holds > 0, "stall never held a request");
        finish_test();

        $display("Summary: %0d checks, %0d errors, %0d stalled cycles",
                 check_count, error_count, stall_holds);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run exceeded %0d cycles with %0d blocks delivered",
                 WATCHDOG_CYCLES, delivered);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top import frontend_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,

    // External controls
    input  wire logic  stall_i,
    input  wire logic  commit_i,

    // Line requests toward the cache
    output fetch_req_t  fetch_req_o
);

    fetch_block_t bpu_blk;
    logic         queue_full;
    ftq_ifu_t     ftq_head;
    logic         ifu_accept;

    // Sequential block source
    block_predictor i_block_predictor (
        .clk          (clk),
        .rst_n        (rst_n),
        .queue_full_i (queue_full),
        .blk_o        (bpu_blk)
    );

    // Decouples prediction from fetch
    ftq i_ftq (
        .clk              (clk),
        .rst_n            (rst_n),
        .bpu_i            (bpu_blk),
        .bpu_queue_full_o (queue_full),
        .backend_commit_i (commit_i),
        .ifu_o            (ftq_head),
        .ifu_accept_i     (ifu_accept)
    );

    // Block to line request splitter
    ifu i_ifu (
        .clk      (clk),
        .rst_n    (rst_n),
        .ftq_i    (ftq_head),
        .accept_o (ifu_accept),
        .stall_i  (stall_i),
        .req_o    (fetch_req_o)
    );

endmodule

`default_nettype wire

// File: logic/ifu.sv
`timescale 1ns/1ps
`default_nettype none

`include "frontend_cfg.svh"

module ifu import frontend_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,

    // Queue head and take strobe
    input  wire ftq_ifu_t ftq_i,
    output logic         accept_o,

    // Hold the current request
    input  wire logic   stall_i,

    output fetch_req_t   req_o
);

    localparam logic [`ADDR_W-1:0] LINE_STEP = `ADDR_W'(`LINE_BYTES);

    ifu_state_e state_q;
    ifu_state_e state_d;
    ftq_ifu_t   blk_q;
    fetch_req_t req_q;
    fetch_req_t req_d;
    fetch_req_t first_req;
    fetch_req_t second_req;
    logic       accept_q;
    logic       take;

    // Line base of an address
    function automatic logic [`ADDR_W-1:0] line_base(input logic [`ADDR_W-1:0] pc);
        return {pc[`ADDR_W-1:LINE_OFF], {LINE_OFF{1'b0}}};
    endfunction

    // Slots that exist in the block
    function automatic logic [`FETCH_WIDTH-1:0] len_mask(input logic [LEN_W-1:0] len);
        logic [`FETCH_WIDTH-1:0] m;
        m = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (i < len) begin
                m[i] = 1'b1;
            end
        end
        return m;
    endfunction

    // Slots that share the line of the start PC
    function automatic logic [`FETCH_WIDTH-1:0] head_mask(input logic [`ADDR_W-1:0] pc,
                                                          input logic [LEN_W-1:0] len);
        logic [`FETCH_WIDTH-1:0] m;
        logic [`ADDR_W-1:0]      slot_pc;
        m = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            slot_pc = pc + `ADDR_W'(4 * i);
            if (i < len && slot_pc[`ADDR_W-1:LINE_OFF] == pc[`ADDR_W-1:LINE_OFF]) begin
                m[i] = 1'b1;
            end
        end
        return m;
    endfunction

    // Request for the start line of the head entry
    always_comb begin
        first_req.valid     = 1'b1;
        first_req.line_addr = line_base(ftq_i.start_pc);
        first_req.slot_mask = head_mask(ftq_i.start_pc, ftq_i.length);
        first_req.idx       = ftq_i.idx;
        first_req.last      = ~ftq_i.is_cross_cacheline;
    end

    // Remaining slots of the latched block
    always_comb begin
        second_req.valid     = 1'b1;
        second_req.line_addr = line_base(blk_q.start_pc) + LINE_STEP;
        second_req.slot_mask = len_mask(blk_q.length)
                             & ~head_mask(blk_q.start_pc, blk_q.length);
        second_req.idx       = blk_q.idx;
        second_req.last      = 1'b1;
    end

    // Take a new block when idle or when the last request leaves now
    assign take = ftq_i.valid & ~stall_i & ((state_q == IDLE) | req_q.last);

    always_comb begin
        state_d = state_q;
        req_d   = req_q;
        if (!stall_i) begin
            if (take) begin
                state_d = FIRST_LINE;
                req_d   = first_req;
            end else if (state_q == FIRST_LINE && !req_q.last) begin
                state_d = SECOND_LINE;
                req_d   = second_req;
            end else begin
                state_d = IDLE;
                req_d   = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            req_q    <= '0;
            accept_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            req_q    <= req_d;
            accept_q <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            blk_q <= ftq_i;
        end
    end

    // Queue pointer moves one cycle after the take while its view looks ahead
    assign accept_o = accept_q;
    assign req_o    = req_q;

    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall_i |=> $stable(req_o)
    );

endmodule

`default_nettype wire

// File: logic/ftq.sv
`timescale 1ns/1ps
`default_nettype none

`include "frontend_cfg.svh"

module ftq import frontend_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,

    // Predictor side
    input  wire fetch_block_t bpu_i,
    output logic         bpu_queue_full_o,

    // Back end retire strobe
    input  wire logic   backend_commit_i,

    // Fetch unit side
    output ftq_ifu_t     ifu_o,
    input  wire logic   ifu_accept_i
);

    // Entry payload and per-entry valid bits
    ftq_block_t               entry_q [`QUEUE_SIZE];
    logic [`QUEUE_SIZE-1:0]   vld_q;

    logic [IDX_W-1:0] bpu_ptr;
    logic [IDX_W-1:0] ifu_ptr;
    logic [IDX_W-1:0] comm_ptr;
    logic [IDX_W-1:0] bpu_ptr_plus1;
    logic [IDX_W-1:0] look_ptr;

    // Three wrapping pointers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bpu_ptr  <= '0;
            ifu_ptr  <= '0;
            comm_ptr <= '0;
        end else begin
            if (bpu_i.valid) begin
                bpu_ptr <= bpu_ptr + 1'b1;
            end
            if (ifu_accept_i) begin
                ifu_ptr <= ifu_ptr + 1'b1;
            end
            if (backend_commit_i) begin
                comm_ptr <= comm_ptr + 1'b1;
            end
        end
    end

    // Commit clears the oldest entry, write fills the newest
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            if (backend_commit_i) begin
                vld_q[comm_ptr] <= 1'b0;
            end
            if (bpu_i.valid) begin
                vld_q[bpu_ptr] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bpu_i.valid) begin
            entry_q[bpu_ptr] <= bpu_i;
        end
    end

    // Look ahead one entry while the head is being taken
    assign look_ptr = ifu_ptr + IDX_W'(ifu_accept_i);

    always_comb begin
        ifu_o.valid              = vld_q[look_ptr];
        ifu_o.is_cross_cacheline = entry_q[look_ptr].is_cross_cacheline;
        ifu_o.start_pc           = entry_q[look_ptr].start_pc;
        ifu_o.length             = entry_q[look_ptr].length;
        ifu_o.idx                = look_ptr;
    end

    // One slot stays empty so full and empty differ
    assign bpu_ptr_plus1    = bpu_ptr + 1'b1;
    assign bpu_queue_full_o = (bpu_ptr_plus1 == comm_ptr);

    a_no_write_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        bpu_i.valid |-> !bpu_queue_full_o
    );

    a_accept_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        ifu_accept_i |-> vld_q[ifu_ptr]
    );

    // Only blocks already handed to the fetch unit may retire
    a_commit_fetched: assert property (
        @(posedge clk) disable iff (!rst_n)
        backend_commit_i |-> (comm_ptr != ifu_ptr)
    );

endmodule

`default_nettype wire

// File: logic/block_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "frontend_cfg.svh"

module block_predictor import frontend_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst_n,

    // Back-pressure from the queue
    input  wire logic         queue_full_i,

    // Block toward the queue
    output fetch_block_t      blk_o
);

    // Bytes covered by one block
    localparam logic [`ADDR_W-1:0] BLK_BYTES = `ADDR_W'(4 * `FETCH_WIDTH);

    // Offset of the last instruction inside a block
    localparam logic [`ADDR_W-1:0] LAST_OFF = `ADDR_W'(4 * (`FETCH_WIDTH - 1));

    logic [`ADDR_W-1:0] pc_q;
    logic [`ADDR_W-1:0] last_pc;
    logic               emit;

    // One fall-through block whenever there is room
    assign emit    = ~queue_full_i;
    assign last_pc = pc_q + LAST_OFF;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `ADDR_W'(`RESET_PC);
        end else if (emit) begin
            pc_q <= pc_q + BLK_BYTES;
        end
    end

    always_comb begin
        blk_o.valid    = emit;
        blk_o.start_pc = pc_q;
        blk_o.length   = LEN_W'(`FETCH_WIDTH);

        // Crossing when first and last instruction sit in different lines
        blk_o.is_cross_cacheline =
            (pc_q[`ADDR_W-1:LINE_OFF] != last_pc[`ADDR_W-1:LINE_OFF]);
    end

    // Queue must never see a write while it reports full
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        queue_full_i |-> !blk_o.valid
    );

endmodule

`default_nettype wire

// File: logic/frontend_pkg.sv
`default_nettype none

`include "frontend_cfg.svh"

package frontend_pkg;

    // Derived widths
    localparam int LEN_W    = $clog2(`FETCH_WIDTH) + 1;
    localparam int IDX_W    = $clog2(`QUEUE_SIZE);
    localparam int LINE_OFF = $clog2(`LINE_BYTES);

    // Block leaving the predictor
    typedef struct packed {
        logic              valid;
        logic              is_cross_cacheline;
        logic [`ADDR_W-1:0] start_pc;
        logic [LEN_W-1:0]  length;
    } fetch_block_t;

    // Same layout, one per queue entry
    typedef fetch_block_t ftq_block_t;

    // Queue head as seen by the fetch unit
    typedef struct packed {
        logic              valid;
        logic              is_cross_cacheline;
        logic [`ADDR_W-1:0] start_pc;
        logic [LEN_W-1:0]  length;
        logic [IDX_W-1:0]  idx;
    } ftq_ifu_t;

    // One cache line request
    typedef struct packed {
        logic                    valid;
        logic [`ADDR_W-1:0]      line_addr;
        logic [`FETCH_WIDTH-1:0] slot_mask;
        logic [IDX_W-1:0]        idx;
        logic                    last;
    } fetch_req_t;

    typedef enum logic [1:0] {
        IDLE,
        FIRST_LINE,
        SECOND_LINE
    } ifu_state_e;

endpackage

`default_nettype wire

// File: logic/frontend_cfg.svh
`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

// Instructions per fetch block, 4 bytes each
`define FETCH_WIDTH 4

// Queue depth, must be a power of two
`define QUEUE_SIZE 8

// Instruction cache line size in bytes
`define LINE_BYTES 16

`define ADDR_W 32

// Start address, not line aligned on purpose
`define RESET_PC 32'h0000_0104

`endif
